/* src/pitaya_pkg.sv */
/* Shared widths, sample types, register map and control word of the analog core.
   Every block and the testbench refer to these by scoped names */
package pitaya_pkg;

  ////////////////////////////////////////
  // Sample widths and types
  ////////////////////////////////////////

  localparam int RAW_W = 16;  // Converter word
  localparam int SMP_W = 14;  // Sample after trimming

  typedef logic        [RAW_W-1:0] raw_t;  // Raw ADC word, offset code
  typedef logic signed [SMP_W-1:0] smp_t;  // Two's complement sample
  typedef logic signed [SMP_W:0]   sum_t;  // One guard bit for the mixer sum
  typedef logic        [SMP_W-1:0] dac_t;  // Negative-slope DAC code

  ////////////////////////////////////////
  // System bus and register map
  ////////////////////////////////////////

  localparam int ADDR_W = 20;
  localparam int DATA_W = 32;

  localparam logic [DATA_W-1:0] HK_ID = 32'h0a1c_0e14;  // ID register contents

  localparam logic [ADDR_W-1:0] REG_ID        = 'h00;  // Read only
  localparam logic [ADDR_W-1:0] REG_CTRL      = 'h04;
  localparam logic [ADDR_W-1:0] REG_EXP_P_DIR = 'h10;
  localparam logic [ADDR_W-1:0] REG_EXP_N_DIR = 'h14;
  localparam logic [ADDR_W-1:0] REG_EXP_P_OUT = 'h18;
  localparam logic [ADDR_W-1:0] REG_EXP_N_OUT = 'h1C;
  localparam logic [ADDR_W-1:0] REG_EXP_P_IN  = 'h20;  // Read only
  localparam logic [ADDR_W-1:0] REG_EXP_N_IN  = 'h24;  // Read only
  localparam logic [ADDR_W-1:0] REG_LED       = 'h30;

  ////////////////////////////////////////
  // Control word
  ////////////////////////////////////////

  // Field layout, LSB first from the bottom
  typedef struct packed {
    logic [26:0] unused;
    logic [2:0]  daisy_mode;    // [0] daisy gate, [1] trig out alt, [2] asg trig select
    logic [1:0]  digital_loop;  // [0] ADC loop, [1] DAC loop
  } hk_ctrl_t;

  // Raw view for bus readback, field view for decoding
  typedef union packed {
    logic [DATA_W-1:0] raw;
    hk_ctrl_t          f;
  } ctrl_word_u;

endpackage

/* src/reset_seq.sv */
/* Core reset generator. Holds the core in reset for RST_HOLD cycles after
   the synthesizer lock rises, and whenever the external reset is high */
`timescale 1ns/1ps

module reset_seq #(
  parameter int RST_HOLD = 64  // Post-lock hold in cycles
) (
  input  logic adc_clk,
  input  logic rst_i,         // External reset, sync active high
  input  logic pll_locked_i,  // Lock from clock synthesizer
  output logic core_rst_o     // Registered core reset
);

  localparam int CW = $clog2(RST_HOLD + 1);

  logic          lock_q;   // Lock seen through one register
  logic          lock_qq;  // Previous value for edge detect
  logic          lock_rise;
  logic [CW-1:0] hold_cnt;

  always_ff @(posedge adc_clk) begin
    lock_q  <= pll_locked_i;
    lock_qq <= lock_q;
  end

  assign lock_rise = lock_q & ~lock_qq;

  // Hold counter
  always_ff @(posedge adc_clk) begin
    if (rst_i || !lock_q) begin
      hold_cnt <= '0;  // Lock drop ends the hold
    end else if (lock_rise || (hold_cnt != '0)) begin
      if (hold_cnt == CW'(RST_HOLD))
        hold_cnt <= '0;  // Hold done
      else
        hold_cnt <= hold_cnt + 1'b1;
    end
  end

  always_ff @(posedge adc_clk) begin
    core_rst_o <= rst_i | (|hold_cnt);
  end

endmodule

/* src/adc_frontend.sv */
/* ADC capture stage. Trims both converter words, converts them to two's
   complement and registers either them or the DAC-side loop samples */
`timescale 1ns/1ps

module adc_frontend (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  pitaya_pkg::raw_t  adc_a_i,    // Converter words, neg-slope offset
  input  pitaya_pkg::raw_t  adc_b_i,
  input  pitaya_pkg::smp_t  loop_a_i,   // Saturated DAC samples
  input  pitaya_pkg::smp_t  loop_b_i,
  input  logic              adc_loop_i, // Digital loopback enable
  output pitaya_pkg::smp_t  adc_a_o,
  output pitaya_pkg::smp_t  adc_b_o
);

  localparam int RW = pitaya_pkg::RAW_W;
  localparam int SW = pitaya_pkg::SMP_W;

  // Drop 2 reserved LSBs, keep sign, invert the rest
  function automatic pitaya_pkg::smp_t to_smp(input pitaya_pkg::raw_t r);
    to_smp = {r[RW-1], ~r[RW-2 -: SW-1]};
  endfunction

  pitaya_pkg::smp_t conv_a;
  pitaya_pkg::smp_t conv_b;

  assign conv_a = to_smp(adc_a_i);
  assign conv_b = to_smp(adc_b_i);

  ////////////////////////////////////////
  // Output register with loop select
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= adc_loop_i ? loop_a_i : conv_a;
      adc_b_o <= adc_loop_i ? loop_b_i : conv_b;
    end
  end

endmodule

/* src/dac_mixer.sv */
/* DAC mixing stage. Sums generator and PID samples with saturation and
   registers the negative-slope DAC codes, or the raw ADC words in loopback */
`timescale 1ns/1ps

module dac_mixer (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  pitaya_pkg::smp_t  asg_a_i,    // Generator samples
  input  pitaya_pkg::smp_t  asg_b_i,
  input  pitaya_pkg::smp_t  pid_a_i,    // Controller samples
  input  pitaya_pkg::smp_t  pid_b_i,
  input  pitaya_pkg::raw_t  adc_a_i,    // Raw converter words for loopback
  input  pitaya_pkg::raw_t  adc_b_i,
  input  logic              dac_loop_i, // DAC-side loopback
  output pitaya_pkg::smp_t  loop_a_o,   // Saturated sample to ADC side
  output pitaya_pkg::smp_t  loop_b_o,
  output pitaya_pkg::dac_t  dac_a_o,
  output pitaya_pkg::dac_t  dac_b_o
);

  localparam int RW = pitaya_pkg::RAW_W;
  localparam int SW = pitaya_pkg::SMP_W;

  // Clamp when the top two sum bits disagree
  function automatic pitaya_pkg::smp_t sat_sum(input pitaya_pkg::sum_t s);
    if (s[SW] ^ s[SW-1])
      sat_sum = {s[SW], {(SW-1){~s[SW]}}};  // Rail of the sum's sign
    else
      sat_sum = s[SW-1:0];
  endfunction

  // Back to negative-slope offset code
  function automatic pitaya_pkg::dac_t to_dac(input pitaya_pkg::smp_t s);
    to_dac = {s[SW-1], ~s[SW-2:0]};
  endfunction

  pitaya_pkg::sum_t sum_a;
  pitaya_pkg::sum_t sum_b;

  assign sum_a = asg_a_i + pid_a_i;  // Sign extended to SW+1
  assign sum_b = asg_b_i + pid_b_i;

  assign loop_a_o = sat_sum(sum_a);
  assign loop_b_o = sat_sum(sum_b);

  ////////////////////////////////////////
  // DAC output register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_a_o <= '0;
      dac_b_o <= '0;
    end else if (dac_loop_i) begin
      dac_a_o <= adc_a_i[RW-1 -: SW];  // Trimmed raw word
      dac_b_o <= adc_b_i[RW-1 -: SW];
    end else begin
      dac_a_o <= to_dac(loop_a_o);
      dac_b_o <= to_dac(loop_b_o);
    end
  end

endmodule

/* src/hk_regs.sv */
/* Housekeeping register block on the system bus. Holds control, LED and
   expansion registers; every strobe is acked one cycle later */
`timescale 1ns/1ps

module hk_regs #(
  parameter int DWE = 8  // Expansion pins per row
) (
  input  logic                          adc_clk,
  input  logic                          rst_i,
  // System bus
  input  logic [pitaya_pkg::ADDR_W-1:0] sys_addr_i,
  input  logic [pitaya_pkg::DATA_W-1:0] sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [pitaya_pkg::DATA_W-1:0] sys_rdata_o,
  output logic                          sys_ack_o,
  // Synchronized pin inputs
  input  logic [DWE-1:0]                exp_p_in_i,
  input  logic [DWE-1:0]                exp_n_in_i,
  // Configuration outputs
  output logic [1:0]                    digital_loop_o,
  output logic [2:0]                    daisy_mode_o,
  output logic [DWE-1:0]                exp_p_dir_o,
  output logic [DWE-1:0]                exp_n_dir_o,
  output logic [DWE-1:0]                exp_p_out_o,
  output logic [DWE-1:0]                exp_n_out_o,
  output logic [7:0]                    led_o
);

  localparam int DW = pitaya_pkg::DATA_W;

  pitaya_pkg::ctrl_word_u ctrl;  // Control word, raw and decoded views

  // Field outputs from the struct view
  assign digital_loop_o = ctrl.f.digital_loop;
  assign daisy_mode_o   = ctrl.f.daisy_mode;

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      ctrl.raw    <= '0;
      exp_p_dir_o <= '0;
      exp_n_dir_o <= '0;
      exp_p_out_o <= '0;
      exp_n_out_o <= '0;
      led_o       <= '0;
    end else if (sys_wen_i) begin
      case (sys_addr_i)
        pitaya_pkg::REG_CTRL:      ctrl.raw    <= sys_wdata_i;
        pitaya_pkg::REG_EXP_P_DIR: exp_p_dir_o <= sys_wdata_i[DWE-1:0];
        pitaya_pkg::REG_EXP_N_DIR: exp_n_dir_o <= sys_wdata_i[DWE-1:0];
        pitaya_pkg::REG_EXP_P_OUT: exp_p_out_o <= sys_wdata_i[DWE-1:0];
        pitaya_pkg::REG_EXP_N_OUT: exp_n_out_o <= sys_wdata_i[DWE-1:0];
        pitaya_pkg::REG_LED:       led_o       <= sys_wdata_i[7:0];
        default: ;  // Read-only or unmapped, ignored
      endcase
    end
  end

  ////////////////////////////////////////
  // Readback and ack
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      sys_rdata_o <= '0;
    end else if (sys_ren_i) begin
      case (sys_addr_i)
        pitaya_pkg::REG_ID:        sys_rdata_o <= pitaya_pkg::HK_ID;
        pitaya_pkg::REG_CTRL:      sys_rdata_o <= ctrl.raw;  // Raw view
        pitaya_pkg::REG_EXP_P_DIR: sys_rdata_o <= {{(DW-DWE){1'b0}}, exp_p_dir_o};
        pitaya_pkg::REG_EXP_N_DIR: sys_rdata_o <= {{(DW-DWE){1'b0}}, exp_n_dir_o};
        pitaya_pkg::REG_EXP_P_OUT: sys_rdata_o <= {{(DW-DWE){1'b0}}, exp_p_out_o};
        pitaya_pkg::REG_EXP_N_OUT: sys_rdata_o <= {{(DW-DWE){1'b0}}, exp_n_out_o};
        pitaya_pkg::REG_EXP_P_IN:  sys_rdata_o <= {{(DW-DWE){1'b0}}, exp_p_in_i};
        pitaya_pkg::REG_EXP_N_IN:  sys_rdata_o <= {{(DW-DWE){1'b0}}, exp_n_in_i};
        pitaya_pkg::REG_LED:       sys_rdata_o <= {{(DW-8){1'b0}}, led_o};
        default:                   sys_rdata_o <= '0;  // Unmapped
      endcase
    end
  end

  // One-cycle ack for either strobe
  always_ff @(posedge adc_clk) begin
    if (rst_i)
      sys_ack_o <= 1'b0;
    else
      sys_ack_o <= sys_wen_i | sys_ren_i;
  end

endmodule

/* src/exp_io_mux.sv */
/* Expansion connector logic. Synchronizes the pin inputs, derives the
   external trigger and registers pin outputs with the trigger-out function */
`timescale 1ns/1ps

module exp_io_mux #(
  parameter int DWE = 8
) (
  input  logic           adc_clk,
  input  logic           rst_i,
  // Pins in
  input  logic [DWE-1:0] exp_p_i,
  input  logic [DWE-1:0] exp_n_i,
  // Register values
  input  logic [DWE-1:0] exp_p_dir_i,
  input  logic [DWE-1:0] exp_n_dir_i,
  input  logic [DWE-1:0] exp_p_out_i,
  input  logic [DWE-1:0] exp_n_out_i,
  input  logic [2:0]     daisy_mode_i,
  // Triggers
  input  logic           scope_trig_i,
  input  logic           asg_trig_i,
  input  logic           daisy_trig_i,  // Level from daisy link
  // Pins out
  output logic [DWE-1:0] exp_p_o,
  output logic [DWE-1:0] exp_p_oe_o,
  output logic [DWE-1:0] exp_n_o,
  output logic [DWE-1:0] exp_n_oe_o,
  // Synced inputs and trigger
  output logic [DWE-1:0] exp_p_sync_o,
  output logic [DWE-1:0] exp_n_sync_o,
  output logic           trig_ext_o
);

  logic [DWE-1:0] p_meta, n_meta;  // First sync stage
  logic           trig_sel;

  // Two-stage input synchronizer
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      p_meta       <= '0;
      n_meta       <= '0;
      exp_p_sync_o <= '0;
      exp_n_sync_o <= '0;
    end else begin
      p_meta       <= exp_p_i;
      n_meta       <= exp_n_i;
      exp_p_sync_o <= p_meta;
      exp_n_sync_o <= n_meta;
    end
  end

  // Ext trigger on p pin 0, blocked by daisy trigger in daisy mode
  assign trig_ext_o = exp_p_sync_o[0] & ~(daisy_mode_i[0] & daisy_trig_i);

  assign trig_sel = daisy_mode_i[2] ? asg_trig_i : scope_trig_i;

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      exp_p_o    <= '0;
      exp_p_oe_o <= '0;
      exp_n_o    <= '0;
      exp_n_oe_o <= '0;
    end else begin
      exp_p_o    <= exp_p_out_i;
      exp_p_oe_o <= exp_p_dir_i;
      exp_n_o    <= exp_n_out_i;
      exp_n_oe_o <= exp_n_dir_i;
      if (daisy_mode_i[1]) begin  // Trigger out on n pin 0
        exp_n_o[0]    <= trig_sel;
        exp_n_oe_o[0] <= 1'b1;
      end
    end
  end

endmodule

/* src/pitaya_core_top.sv */
/* Top level of the analog core on adc_clk. Connects reset sequencer, ADC
   and DAC paths, housekeeping registers and expansion connector logic */
`timescale 1ns/1ps

module pitaya_core_top #(
  parameter int DWE      = 8,   // Expansion pins, minimum 8
  parameter int RST_HOLD = 64   // Post-lock reset hold
) (
  input  logic                          adc_clk,
  input  logic                          rst_i,
  input  logic                          pll_locked_i,
  // ADC
  input  pitaya_pkg::raw_t              adc_a_i,
  input  pitaya_pkg::raw_t              adc_b_i,
  output pitaya_pkg::smp_t              adc_a_o,
  output pitaya_pkg::smp_t              adc_b_o,
  // Generator and controller samples
  input  pitaya_pkg::smp_t              asg_a_i,
  input  pitaya_pkg::smp_t              asg_b_i,
  input  pitaya_pkg::smp_t              pid_a_i,
  input  pitaya_pkg::smp_t              pid_b_i,
  // DAC
  output pitaya_pkg::dac_t              dac_a_o,
  output pitaya_pkg::dac_t              dac_b_o,
  // System bus
  input  logic [pitaya_pkg::ADDR_W-1:0] sys_addr_i,
  input  logic [pitaya_pkg::DATA_W-1:0] sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [pitaya_pkg::DATA_W-1:0] sys_rdata_o,
  output logic                          sys_ack_o,
  // Triggers
  input  logic                          scope_trig_i,
  input  logic                          asg_trig_i,
  input  logic                          daisy_trig_i,
  output logic                          trig_ext_o,
  // Expansion connector
  input  logic [DWE-1:0]                exp_p_i,
  input  logic [DWE-1:0]                exp_n_i,
  output logic [DWE-1:0]                exp_p_o,
  output logic [DWE-1:0]                exp_p_oe_o,
  output logic [DWE-1:0]                exp_n_o,
  output logic [DWE-1:0]                exp_n_oe_o,
  // LED
  output logic [7:0]                    led_o
);

  logic             core_rst;
  pitaya_pkg::smp_t loop_a, loop_b;      // Saturated DAC samples
  logic [1:0]       digital_loop;
  logic [2:0]       daisy_mode;
  logic [DWE-1:0]   exp_p_dir, exp_n_dir;
  logic [DWE-1:0]   exp_p_out, exp_n_out;
  logic [DWE-1:0]   exp_p_sync, exp_n_sync;

  reset_seq #(.RST_HOLD(RST_HOLD)) reset_seq_inst (
    .adc_clk      (adc_clk),
    .rst_i        (rst_i),
    .pll_locked_i (pll_locked_i),
    .core_rst_o   (core_rst)
  );

  adc_frontend adc_frontend_inst (
    .adc_clk    (adc_clk),
    .rst_i      (core_rst),
    .adc_a_i    (adc_a_i),
    .adc_b_i    (adc_b_i),
    .loop_a_i   (loop_a),
    .loop_b_i   (loop_b),
    .adc_loop_i (digital_loop[0]),
    .adc_a_o    (adc_a_o),
    .adc_b_o    (adc_b_o)
  );

  dac_mixer dac_mixer_inst (
    .adc_clk    (adc_clk),
    .rst_i      (core_rst),
    .asg_a_i    (asg_a_i),
    .asg_b_i    (asg_b_i),
    .pid_a_i    (pid_a_i),
    .pid_b_i    (pid_b_i),
    .adc_a_i    (adc_a_i),
    .adc_b_i    (adc_b_i),
    .dac_loop_i (digital_loop[1]),
    .loop_a_o   (loop_a),
    .loop_b_o   (loop_b),
    .dac_a_o    (dac_a_o),
    .dac_b_o    (dac_b_o)
  );

  hk_regs #(.DWE(DWE)) hk_regs_inst (
    .adc_clk        (adc_clk),
    .rst_i          (core_rst),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (sys_wen_i),
    .sys_ren_i      (sys_ren_i),
    .sys_rdata_o    (sys_rdata_o),
    .sys_ack_o      (sys_ack_o),
    .exp_p_in_i     (exp_p_sync),
    .exp_n_in_i     (exp_n_sync),
    .digital_loop_o (digital_loop),
    .daisy_mode_o   (daisy_mode),
    .exp_p_dir_o    (exp_p_dir),
    .exp_n_dir_o    (exp_n_dir),
    .exp_p_out_o    (exp_p_out),
    .exp_n_out_o    (exp_n_out),
    .led_o          (led_o)
  );

  exp_io_mux #(.DWE(DWE)) exp_io_mux_inst (
    .adc_clk      (adc_clk),
    .rst_i        (core_rst),
    .exp_p_i      (exp_p_i),
    .exp_n_i      (exp_n_i),
    .exp_p_dir_i  (exp_p_dir),
    .exp_n_dir_i  (exp_n_dir),
    .exp_p_out_i  (exp_p_out),
    .exp_n_out_i  (exp_n_out),
    .daisy_mode_i (daisy_mode),
    .scope_trig_i (scope_trig_i),
    .asg_trig_i   (asg_trig_i),
    .daisy_trig_i (daisy_trig_i),
    .exp_p_o      (exp_p_o),
    .exp_p_oe_o   (exp_p_oe_o),
    .exp_n_o      (exp_n_o),
    .exp_n_oe_o   (exp_n_oe_o),
    .exp_p_sync_o (exp_p_sync),
    .exp_n_sync_o (exp_n_sync),
    .trig_ext_o   (trig_ext_o)
  );

endmodule

/* tb/tb_pitaya_core.sv */
/* Self-checking testbench for the analog core. Random stimulus against a cycle
   model, bus register checks, expansion pins and reset sequencing */
`timescale 1ns/1ps

module tb_pitaya_core;

  localparam int DWE      = 8;
  localparam int RST_HOLD = 64;
  localparam int SW       = pitaya_pkg::SMP_W;
  localparam int SMAX     = 2**(SW-1) - 1;
  localparam int SMIN     = -(2**(SW-1));
  localparam logic [SW-1:0] LOW_MASK = (1 << (SW-1)) - 1;  // Magnitude bits

  // Test lengths in cycles
  localparam int N_DATA  = 500;
  localparam int N_REG   = 200;
  localparam int N_LOOP  = 150;
  localparam int N_EXP   = 60;
  localparam int EXP_RUN = 8;
  localparam int TEST_CYCLES = 12 + N_DATA + 3*N_REG + 3*(N_LOOP + 3) + 3
                             + N_EXP*(3 + EXP_RUN) + RST_HOLD + 40;

  logic                          adc_clk;
  logic                          rst_i;
  logic                          pll_locked_i;
  pitaya_pkg::raw_t              adc_a_i, adc_b_i;
  pitaya_pkg::smp_t              adc_a_o, adc_b_o;
  pitaya_pkg::smp_t              asg_a_i, asg_b_i, pid_a_i, pid_b_i;
  pitaya_pkg::dac_t              dac_a_o, dac_b_o;
  logic [pitaya_pkg::ADDR_W-1:0] sys_addr_i;
  logic [pitaya_pkg::DATA_W-1:0] sys_wdata_i, sys_rdata_o;
  logic                          sys_wen_i, sys_ren_i, sys_ack_o;
  logic                          scope_trig_i, asg_trig_i, daisy_trig_i, trig_ext_o;
  logic [DWE-1:0]                exp_p_i, exp_n_i;
  logic [DWE-1:0]                exp_p_o, exp_p_oe_o, exp_n_o, exp_n_oe_o;
  logic [7:0]                    led_o;

  // Model state
  pitaya_pkg::ctrl_word_u ctrl_m;
  logic [DWE-1:0]         pdir_m, ndir_m, pout_m, nout_m;
  logic [7:0]             led_m;
  pitaya_pkg::smp_t       adc_a_m, adc_b_m;
  pitaya_pkg::dac_t       dac_a_m, dac_b_m;
  logic [DWE-1:0]         p_s1, p_s2, n_s1, n_s2;   // Pin sync model
  logic [DWE-1:0]         p_o_m, p_oe_m, n_o_m, n_oe_m;

  int smp_errs = 0;
  int dac_errs = 0;
  int word_errs = 0;
  int pin_errs = 0;
  int bit_errs = 0;
  int seq_errs = 0;
  int seed_val;

  pitaya_core_top #(.DWE(DWE), .RST_HOLD(RST_HOLD)) pitaya_core_top_inst (.*);

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;  // 8 ns period
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Offset code counts down, so flipping the magnitude bits gives two's complement
  function automatic pitaya_pkg::smp_t raw_to_smp(input pitaya_pkg::raw_t r);
    return pitaya_pkg::smp_t'(r >> 2) ^ LOW_MASK;
  endfunction

  function automatic pitaya_pkg::smp_t mix(input pitaya_pkg::smp_t a,
                                           input pitaya_pkg::smp_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > SMAX)
      s = SMAX;       // Clip at the rails
    else if (s < SMIN)
      s = SMIN;
    return pitaya_pkg::smp_t'(s);
  endfunction

  function automatic pitaya_pkg::dac_t smp_to_dac(input pitaya_pkg::smp_t s);
    return pitaya_pkg::dac_t'(s) ^ LOW_MASK;
  endfunction

  function automatic logic [pitaya_pkg::DATA_W-1:0] read_model(
      input logic [pitaya_pkg::ADDR_W-1:0] a);
    case (a)
      pitaya_pkg::REG_ID:        return pitaya_pkg::HK_ID;
      pitaya_pkg::REG_CTRL:      return ctrl_m.raw;
      pitaya_pkg::REG_EXP_P_DIR: return 32'(pdir_m);
      pitaya_pkg::REG_EXP_N_DIR: return 32'(ndir_m);
      pitaya_pkg::REG_EXP_P_OUT: return 32'(pout_m);
      pitaya_pkg::REG_EXP_N_OUT: return 32'(nout_m);
      pitaya_pkg::REG_EXP_P_IN:  return 32'(p_s2);
      pitaya_pkg::REG_EXP_N_IN:  return 32'(n_s2);
      pitaya_pkg::REG_LED:       return 32'(led_m);
      default:                   return '0;  // Unmapped
    endcase
  endfunction

  // Registered outputs, one cycle behind the inputs
  always @(posedge adc_clk) begin
    adc_a_m <= ctrl_m.f.digital_loop[0] ? mix(asg_a_i, pid_a_i) : raw_to_smp(adc_a_i);
    adc_b_m <= ctrl_m.f.digital_loop[0] ? mix(asg_b_i, pid_b_i) : raw_to_smp(adc_b_i);
    dac_a_m <= ctrl_m.f.digital_loop[1] ? pitaya_pkg::dac_t'(adc_a_i >> 2)
                                        : smp_to_dac(mix(asg_a_i, pid_a_i));
    dac_b_m <= ctrl_m.f.digital_loop[1] ? pitaya_pkg::dac_t'(adc_b_i >> 2)
                                        : smp_to_dac(mix(asg_b_i, pid_b_i));
    p_s1    <= exp_p_i;
    p_s2    <= p_s1;
    n_s1    <= exp_n_i;
    n_s2    <= n_s1;
    p_o_m   <= pout_m;
    p_oe_m  <= pdir_m;
    n_o_m   <= nout_m;
    n_oe_m  <= ndir_m;
    if (ctrl_m.f.daisy_mode[1]) begin  // Trigger out on n pin 0
      n_o_m[0]  <= ctrl_m.f.daisy_mode[2] ? asg_trig_i : scope_trig_i;
      n_oe_m[0] <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_smp(input pitaya_pkg::smp_t got, input pitaya_pkg::smp_t exp,
                           input string what);
    if (got !== exp) begin
      smp_errs++;
      $display("Error at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_dac(input pitaya_pkg::dac_t got, input pitaya_pkg::dac_t exp,
                           input string what);
    if (got !== exp) begin
      dac_errs++;
      $display("Error at %0t ns: %s got 0x%h, expected 0x%h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input logic [pitaya_pkg::DATA_W-1:0] got,
                            input logic [pitaya_pkg::DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      word_errs++;
      $display("Error at %0t ns: %s got 0x%h, expected 0x%h", $time, what, got, exp);
    end
  endtask

  task automatic check_pins(input logic [DWE-1:0] got, input logic [DWE-1:0] exp,
                            input string what);
    if (got !== exp) begin
      pin_errs++;
      $display("Error at %0t ns: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      bit_errs++;
      $display("Error at %0t ns: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Bus access, called on a falling edge
  ////////////////////////////////////////

  task automatic bus_write(input logic [pitaya_pkg::ADDR_W-1:0] addr,
                           input logic [pitaya_pkg::DATA_W-1:0] data);
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;
    @(negedge adc_clk);
    sys_wen_i = 1'b0;
    check_bit(sys_ack_o, 1'b1, "write ack");
    case (addr)
      pitaya_pkg::REG_CTRL:      ctrl_m.raw = data;
      pitaya_pkg::REG_EXP_P_DIR: pdir_m = data[DWE-1:0];
      pitaya_pkg::REG_EXP_N_DIR: ndir_m = data[DWE-1:0];
      pitaya_pkg::REG_EXP_P_OUT: pout_m = data[DWE-1:0];
      pitaya_pkg::REG_EXP_N_OUT: nout_m = data[DWE-1:0];
      pitaya_pkg::REG_LED:       led_m  = data[7:0];
      default: ;                 // Read-only or unmapped
    endcase
    @(negedge adc_clk);
    check_bit(sys_ack_o, 1'b0, "ack width after write");
    check_word(32'(led_o), 32'(led_m), "led_o");
  endtask

  task automatic bus_read(input logic [pitaya_pkg::ADDR_W-1:0] addr,
                          output logic [pitaya_pkg::DATA_W-1:0] data);
    sys_addr_i = addr;
    sys_ren_i  = 1'b1;
    @(negedge adc_clk);
    sys_ren_i = 1'b0;
    check_bit(sys_ack_o, 1'b1, "read ack");
    data = sys_rdata_o;  // Valid in the ack cycle
    @(negedge adc_clk);
    check_bit(sys_ack_o, 1'b0, "ack width after read");
  endtask

  function automatic logic [pitaya_pkg::ADDR_W-1:0] pick_addr(input int i);
    case (i)
      0:       return pitaya_pkg::REG_ID;
      1:       return pitaya_pkg::REG_CTRL;
      2:       return pitaya_pkg::REG_EXP_P_DIR;
      3:       return pitaya_pkg::REG_EXP_N_DIR;
      4:       return pitaya_pkg::REG_EXP_P_OUT;
      5:       return pitaya_pkg::REG_EXP_N_OUT;
      6:       return pitaya_pkg::REG_EXP_P_IN;
      7:       return pitaya_pkg::REG_EXP_N_IN;
      8:       return pitaya_pkg::REG_LED;
      9:       return 'h08;    // Holes in the map
      10:      return 'h3C;
      default: return 'h2000;
    endcase
  endfunction

  function automatic pitaya_pkg::smp_t rand_smp();
    case ($urandom_range(0, 7))
      0:       return pitaya_pkg::smp_t'(SMAX);
      1:       return pitaya_pkg::smp_t'(SMIN);
      default: return pitaya_pkg::smp_t'($urandom);
    endcase
  endfunction

  ////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////

  // ADC and DAC paths together, checked every cycle
  task automatic run_samples(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge adc_clk);
      check_smp(adc_a_o, adc_a_m, "adc_a_o");
      check_smp(adc_b_o, adc_b_m, "adc_b_o");
      check_dac(dac_a_o, dac_a_m, "dac_a_o");
      check_dac(dac_b_o, dac_b_m, "dac_b_o");
      adc_a_i = pitaya_pkg::raw_t'($urandom);
      adc_b_i = pitaya_pkg::raw_t'($urandom);
      asg_a_i = rand_smp();
      asg_b_i = rand_smp();
      pid_a_i = rand_smp();
      pid_b_i = rand_smp();
    end
  endtask

  task automatic run_registers(input int n);
    logic [pitaya_pkg::ADDR_W-1:0] a;
    logic [pitaya_pkg::DATA_W-1:0] d;
    bus_read(pitaya_pkg::REG_ID, d);
    check_word(d, pitaya_pkg::HK_ID, "ID register");
    for (int i = 0; i < n; i++) begin
      a = pick_addr($urandom_range(0, 11));
      if ($urandom_range(0, 1)) begin
        bus_write(a, $urandom);
      end else begin
        bus_read(a, d);
        check_word(d, read_model(a), $sformatf("read 0x%0h", a));
      end
    end
  endtask

  // Random config write, then a burst of pin and trigger activity
  task automatic run_expansion(input int n);
    logic [pitaya_pkg::ADDR_W-1:0] a;
    for (int k = 0; k < n; k++) begin
      a = pick_addr($urandom_range(1, 5));
      bus_write(a, $urandom);
      repeat (EXP_RUN) begin
        @(negedge adc_clk);
        check_pins(exp_p_o, p_o_m, "exp_p_o");
        check_pins(exp_p_oe_o, p_oe_m, "exp_p_oe_o");
        check_pins(exp_n_o, n_o_m, "exp_n_o");
        check_pins(exp_n_oe_o, n_oe_m, "exp_n_oe_o");
        // Synced p pin 0 unless daisy gating and daisy trigger are both high
        check_bit(trig_ext_o,
                  (ctrl_m.f.daisy_mode[0] && daisy_trig_i) ? 1'b0 : p_s2[0],
                  "trig_ext_o");
        exp_p_i      = DWE'($urandom);
        exp_n_i      = DWE'($urandom);
        scope_trig_i = $urandom_range(0, 1);
        asg_trig_i   = $urandom_range(0, 1);
        daisy_trig_i = $urandom_range(0, 1);
      end
    end
  endtask

  task automatic run_reset_seq();
    bit in_hold;
    bit ended;
    bus_write(pitaya_pkg::REG_CTRL, '0);
    bus_write(pitaya_pkg::REG_LED, 32'hA5);
    pll_locked_i = 1'b0;
    repeat (4) @(negedge adc_clk);
    pll_locked_i = 1'b1;      // Sampled at the next rising edge
    sys_addr_i   = pitaya_pkg::REG_LED;
    sys_ren_i    = 1'b1;      // Read every cycle to watch the ack
    for (int k = 1; k <= RST_HOLD + 4; k++) begin
      @(negedge adc_clk);
      // Blocks are in reset from the 4th edge until RST_HOLD+3
      in_hold = (k >= 4) && (k <= RST_HOLD + 3);
      check_bit(sys_ack_o, !in_hold, "ack around hold");
      check_word(32'(led_o), (k < 4) ? 32'hA5 : 32'h0, "led_o around hold");
      if (in_hold) begin
        check_smp(adc_a_o, '0, "adc_a_o in hold");
        check_dac(dac_a_o, '0, "dac_a_o in hold");
      end
    end
    // Lock drop in the middle of a hold
    pll_locked_i = 1'b0;
    repeat (4) @(negedge adc_clk);
    pll_locked_i = 1'b1;
    repeat (10) @(negedge adc_clk);
    check_bit(sys_ack_o, 1'b0, "ack before lock drop");
    pll_locked_i = 1'b0;
    ended = 1'b0;
    for (int w = 0; w < 8 && !ended; w++) begin
      @(negedge adc_clk);
      ended = sys_ack_o;
    end
    if (!ended) begin
      seq_errs++;
      $display("Core reset was still held 8 cycles after the lock dropped");
    end
    sys_ren_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    seed_val     = $urandom(32'h3f4289b4);
    rst_i        = 1'b1;
    pll_locked_i = 1'b1;
    adc_a_i      = '0;
    adc_b_i      = '0;
    asg_a_i      = '0;
    asg_b_i      = '0;
    pid_a_i      = '0;
    pid_b_i      = '0;
    sys_addr_i   = '0;
    sys_wdata_i  = '0;
    sys_wen_i    = 1'b0;
    sys_ren_i    = 1'b1;            // Read strobe held through reset
    scope_trig_i = 1'b0;
    asg_trig_i   = 1'b0;
    daisy_trig_i = 1'b0;
    exp_p_i      = DWE'($urandom);  // Held until the expansion test
    exp_n_i      = DWE'($urandom);
    ctrl_m.raw   = '0;
    pdir_m       = '0;
    ndir_m       = '0;
    pout_m       = '0;
    nout_m       = '0;
    led_m        = '0;

    repeat (10) @(negedge adc_clk);
    check_bit(sys_ack_o, 1'b0, "ack in reset");
    check_word(32'(led_o), '0, "led_o in reset");
    check_dac(dac_a_o, '0, "dac_a_o in reset");
    check_smp(adc_a_o, '0, "adc_a_o in reset");
    check_pins(exp_n_oe_o, '0, "exp_n_oe_o in reset");
    rst_i     = 1'b0;
    sys_ren_i = 1'b0;
    repeat (2) @(negedge adc_clk);  // Core reset follows one cycle later

    run_samples(N_DATA);
    run_registers(N_REG);
    for (int m = 1; m <= 3; m++) begin
      bus_write(pitaya_pkg::REG_CTRL, m);  // ADC, DAC, then both loops
      run_samples(N_LOOP);
    end
    bus_write(pitaya_pkg::REG_CTRL, '0);
    run_expansion(N_EXP);
    run_reset_seq();

    $display("Errors: smp %0d, dac %0d, word %0d, pins %0d, bit %0d, reset %0d",
             smp_errs, dac_errs, word_errs, pin_errs, bit_errs, seq_errs);
    if (smp_errs + dac_errs + word_errs + pin_errs + bit_errs + seq_errs == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (2 * TEST_CYCLES) @(posedge adc_clk);
    $display("Timeout: run still going after %0d cycles", 2 * TEST_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* pitaya_core.f */
src/pitaya_pkg.sv
src/reset_seq.sv
src/adc_frontend.sv
src/dac_mixer.sv
src/hk_regs.sv
src/exp_io_mux.sv
src/pitaya_core_top.sv
tb/tb_pitaya_core.sv
